// ==== flist.f ====
+incdir+include
rtl/cpu_types_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/pipeline_cpu.sv
tb/cpu_checker.sv
tb/tb_pipeline_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f \
	--top-module tb_pipeline_cpu -o sim_pipeline_cpu
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_pipeline_cpu > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "^Test OK$" sim.log; then
	exit 0
fi
exit 1

// ==== tb/tb_pipeline_cpu.sv ====
// testbench for the pipelined core
// clock and reset, LFSR random programs, instruction and data
// memory models with random hit latency, per-program result lines
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_cpu;
	import cpu_types_pkg::*;

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 64;
	localparam int SUB_AT = 240;
	localparam int MAIN_LIMIT = 224;
	localparam int NUM_TESTS = 4;
	localparam int TIMEOUT_CYCLES = 40000;

	logic clk, rst, imem_ren, ihit, dmem_ren, dmem_wen, dhit, halt;
	logic [31:0] imem_addr, instr, dmem_addr, dmem_store, dmem_load;
	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] dinit [DMEM_WORDS];
	logic [31:0] lfsr;
	int wp, i_cnt, d_cnt, errors, stores_seen, stores_expected;
	int cycles, passed, failed, err_before;
	logic model_ok, timed_out;

	pipeline_cpu i_dut (
		.clk        (clk),
		.rst        (rst),
		.imem_addr  (imem_addr),
		.imem_ren   (imem_ren),
		.instr      (instr),
		.ihit       (ihit),
		.dmem_addr  (dmem_addr),
		.dmem_ren   (dmem_ren),
		.dmem_wen   (dmem_wen),
		.dmem_store (dmem_store),
		.dmem_load  (dmem_load),
		.dhit       (dhit),
		.halt       (halt)
	);

	cpu_checker u_checker (
		.clk             (clk),
		.rst             (rst),
		.prog            (imem),
		.dinit           (dinit),
		.halt            (halt),
		.imem_ren        (imem_ren),
		.dmem_ren        (dmem_ren),
		.dmem_wen        (dmem_wen),
		.dhit            (dhit),
		.dmem_addr       (dmem_addr),
		.dmem_store      (dmem_store),
		.errors          (errors),
		.stores_seen     (stores_seen),
		.stores_expected (stores_expected),
		.model_ok        (model_ok)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// galois lfsr stepped once for each bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [4:0] pick_reg();
		return 5'(1 + rand_bits(3) % 7);
	endfunction

	// hit comes one to three cycles after the request
	function automatic int pick_delay();
		return 1 + int'(rand_bits(2) % 3);
	endfunction

	function automatic logic [31:0] fill_word(input int idx);
		return (32'(idx) * 32'h9E37_79B9) ^ 32'h0F0F_1234;
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input funct_t fn);
		return {RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_t op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input opcode_t op, input int idx);
		return {op, 26'(idx)};
	endfunction

	task automatic put(input logic [31:0] w);
		imem[wp] = w;
		wp++;
	endtask

	// store to r0-based word offset inside the data array
	task automatic put_store(input logic [4:0] rt);
		put(enc_i(SW, 5'd0, rt, {8'd0, 6'(rand_bits(6)), 2'b00}));
	endtask

	task automatic put_alu(input logic [4:0] rd, input logic [4:0] ra);
		logic [4:0] rb;
		rb = pick_reg();
		case (rand_bits(3) % 6)
			0: put(enc_r(ra, rb, rd, ADDU));
			1: put(enc_r(ra, rb, rd, SUBU));
			2: put(enc_r(ra, rb, rd, AND));
			3: put(enc_r(ra, rb, rd, OR));
			4: put(enc_r(ra, rb, rd, SLT));
			default: put(enc_i(ADDIU, ra, rd, 16'(rand_bits(16))));
		endcase
	endtask

	task automatic gen_program();
		int n;
		logic [4:0] ra, rb;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dinit[i] = fill_word(i);
			dmem[i] = dinit[i];
		end
		wp = 0;
		for (int r = 1; r < 8; r++)
			put(enc_i(ADDIU, 5'd0, 5'(r), 16'(rand_bits(16))));
		while (wp < MAIN_LIMIT) begin
			case (rand_bits(3) % 5)
				0: begin
					ra = pick_reg();
					put_alu(ra, pick_reg());
					put_store(ra);
				end
				// load then immediate use
				1: begin
					ra = pick_reg();
					rb = pick_reg();
					put(enc_i(LW, 5'd0, ra, {8'd0, 6'(rand_bits(6)), 2'b00}));
					put_alu(rb, ra);
					put_store(rb);
				end
				// forward branch over stores with equal regs half the time
				2: begin
					n = 1 + int'(rand_bits(2) % 3);
					ra = pick_reg();
					rb = rand_bits(1) ? ra : pick_reg();
					put(enc_i(rand_bits(1) ? BEQ : BNE, ra, rb, 16'(n)));
					for (int k = 0; k < n; k++)
						put_store(pick_reg());
				end
				3: begin
					n = 1 + int'(rand_bits(1));
					put(enc_j(J, wp + 1 + n));
					for (int k = 0; k < n; k++)
						put_store(pick_reg());
				end
				default: put(enc_j(JAL, SUB_AT));
			endcase
		end
		put(enc_j(HALT, 0));
		// subroutine of three ALU ops and a store before the return
		wp = SUB_AT;
		for (int k = 0; k < 3; k++)
			put_alu(pick_reg(), pick_reg());
		put_store(pick_reg());
		put(enc_r(5'd31, 5'd0, 5'd0, JR));
	endtask

	// memory responder where a waiting data access always goes first
	always @(negedge clk) begin
		ihit = 1'b0;
		dhit = 1'b0;
		if (rst) begin
			i_cnt = 0;
			d_cnt = 0;
		end else if (dmem_ren || dmem_wen) begin
			if (d_cnt == 0)
				d_cnt = pick_delay();
			d_cnt--;
			if (d_cnt == 0) begin
				dhit = 1'b1;
				if (dmem_wen)
					dmem[dmem_addr[7:2]] = dmem_store;
				else
					dmem_load = dmem[dmem_addr[7:2]];
			end
		end else if (imem_ren) begin
			if (i_cnt == 0)
				i_cnt = pick_delay();
			i_cnt--;
			if (i_cnt == 0) begin
				ihit = 1'b1;
				instr = imem[imem_addr[9:2]];
			end
		end
	end

	initial begin
		rst = 1'b1;
		ihit = 1'b0;
		dhit = 1'b0;
		instr = '0;
		dmem_load = '0;
		lfsr = 32'd71301;
		passed = 0;
		failed = 0;
		timed_out = 1'b0;
		for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
			gen_program();
			rst <= 1'b1;
			repeat (8) @(negedge clk);
			rst <= 1'b0;
			err_before = errors;
			cycles = 0;
			while (!halt && cycles < TIMEOUT_CYCLES) begin
				@(negedge clk);
				cycles++;
			end
			if (!halt) begin
				$display("program %0d timed out, halt never rose in %0d cycles", t, cycles);
				timed_out = 1'b1;
				failed++;
			end else begin
				// watch a while longer for late stores
				repeat (16) @(negedge clk);
				if (!model_ok)
					$display("program %0d never reaches HALT in the model", t);
				if (stores_seen != stores_expected)
					$display("program %0d made %0d stores, model made %0d",
						t, stores_seen, stores_expected);
				if (model_ok && stores_seen == stores_expected && errors == err_before)
					passed++;
				else
					failed++;
				$display("program %0d: %0d stores in %0d cycles, %s", t, stores_seen,
					cycles, (model_ok && stores_seen == stores_expected
					&& errors == err_before) ? "passed" : "failed");
			end
		end
		$display("programs passed %0d, failed %0d, checker errors %0d",
			passed, failed, errors);
		if (failed == 0 && errors == 0 && !timed_out)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/cpu_checker.sv ====
// checker for the pipelined core
// in-order ISA model of the loaded program, expected store and load lists,
// store-by-store and load address compare, fetch request level,
// halt level and store-after-halt checks
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
	input  wire         clk,
	input  wire         rst,
	input  wire  [31:0] prog [256],
	input  wire  [31:0] dinit [64],
	input  wire         halt,
	input  wire         imem_ren,
	input  wire         dmem_ren,
	input  wire         dmem_wen,
	input  wire         dhit,
	input  wire  [31:0] dmem_addr,
	input  wire  [31:0] dmem_store,
	output int          errors,
	output int          stores_seen,
	output int          stores_expected,
	output logic        model_ok
);
	import cpu_types_pkg::*;

	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] exp_load [$];
	logic halt_seen;
	int loads_seen;

	initial begin
		errors = 0;
		stores_seen = 0;
		stores_expected = 0;
		model_ok = 1'b0;
		halt_seen = 1'b0;
		loads_seen = 0;
	end

	// architectural run without delay slots that stops at HALT
	task automatic run_model();
		logic [31:0] r [32];
		logic [31:0] m [64];
		logic [31:0] pc, w, a, b, simm, addr, next_pc;
		int steps;
		exp_addr.delete();
		exp_data.delete();
		exp_load.delete();
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		for (int i = 0; i < 64; i++)
			m[i] = dinit[i];
		pc = '0;
		steps = 0;
		model_ok = 1'b0;
		while (!model_ok && steps < 10000) begin
			w = prog[pc[9:2]];
			a = r[w[25:21]];
			b = r[w[20:16]];
			simm = {{16{w[15]}}, w[15:0]};
			addr = a + simm;
			next_pc = pc + 4;
			case (opcode_t'(w[31:26]))
				RTYPE: begin
					case (funct_t'(w[5:0]))
						ADDU: r[w[15:11]] = a + b;
						SUBU: r[w[15:11]] = a - b;
						AND:  r[w[15:11]] = a & b;
						OR:   r[w[15:11]] = a | b;
						SLT:  r[w[15:11]] = {31'b0, $signed(a) < $signed(b)};
						JR:   next_pc = a;
						default: ;
					endcase
				end
				ADDIU: r[w[20:16]] = a + simm;
				LW: begin
					r[w[20:16]] = m[addr[7:2]];
					exp_load.push_back(addr);
				end
				SW: begin
					m[addr[7:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				BEQ: if (a == b) next_pc = pc + 4 + {simm[29:0], 2'b00};
				BNE: if (a != b) next_pc = pc + 4 + {simm[29:0], 2'b00};
				J:   next_pc = {next_pc[31:28], w[25:0], 2'b00};
				JAL: begin
					r[31] = pc + 4;
					next_pc = {next_pc[31:28], w[25:0], 2'b00};
				end
				HALT: model_ok = 1'b1;
				default: ;
			endcase
			r[0] = '0;
			pc = next_pc;
			steps++;
		end
		stores_expected = exp_addr.size();
	endtask

	// outputs of the DUT are sampled before the edge updates them
	always @(posedge clk) begin
		if (rst) begin
			run_model();
			stores_seen = 0;
			loads_seen = 0;
			halt_seen = 1'b0;
		end else begin
			if (dmem_ren && dhit) begin
				if (loads_seen >= exp_load.size()) begin
					$display("extra load from %h, program has only %0d loads",
						dmem_addr, exp_load.size());
					errors++;
				end else if (dmem_addr !== exp_load[loads_seen]) begin
					$display("** Error at %0t: load %0d read %h, model reads %h",
						$time, loads_seen, dmem_addr, exp_load[loads_seen]);
					errors++;
				end
				loads_seen++;
			end
			if (dmem_wen && dhit) begin
				if (halt_seen) begin
					$display("store to %h issued after halt", dmem_addr);
					errors++;
				end else if (stores_seen >= stores_expected) begin
					$display("extra store to %h, program has only %0d stores",
						dmem_addr, stores_expected);
					errors++;
				end else if (dmem_addr !== exp_addr[stores_seen]
						|| dmem_store !== exp_data[stores_seen]) begin
					$display("** Error at %0t: store %0d wrote %h to %h, model has %h to %h",
						$time, stores_seen, dmem_store, dmem_addr,
						exp_data[stores_seen], exp_addr[stores_seen]);
					errors++;
				end
				stores_seen++;
			end
			if (!halt && !imem_ren) begin
				$display("instruction fetch request dropped while the core runs");
				errors++;
			end
			if (halt_seen && !halt) begin
				$display("halt dropped after it was raised");
				errors++;
			end
			if (halt && !halt_seen && loads_seen != exp_load.size()) begin
				$display("halt after %0d loads, model made %0d",
					loads_seen, exp_load.size());
				errors++;
			end
			if (halt)
				halt_seen = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pipeline_cpu.sv ====
// core top level
// five-stage pipeline: fetch, decode, execute, memory
// stages and the hazard unit, instruction and data
// memories sit outside on hit-strobe ports
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module pipeline_cpu (
	input  wire                          clk,
	input  wire                          rst,
	output logic [`CPU_DATA_W-1:0]       imem_addr,
	output logic                         imem_ren,
	input  wire [`CPU_DATA_W-1:0]        instr,
	input  wire                          ihit,
	output logic [`CPU_DATA_W-1:0]       dmem_addr,
	output logic                         dmem_ren,
	output logic                         dmem_wen,
	output logic [`CPU_DATA_W-1:0]       dmem_store,
	input  wire [`CPU_DATA_W-1:0]        dmem_load,
	input  wire                          dhit,
	output logic                         halt
);
	import cpu_types_pkg::*;

	// hazard controls
	logic enable_pc, enable_if_id, enable_id_ex, enable_ex_mem, enable_mem_wb;
	logic flush_if_id, flush_id_ex, flush_ex_mem, flush_mem_wb;
	pc_sel_t pc_sel;

	// IF/ID and decode outputs
	logic [`CPU_DATA_W-1:0] instr_if_id, pc4_if_id, jr_addr;
	logic [`CPU_DATA_W-1:0] rs_val, rt_val, imm, pc4_id_ex;
	logic [`CPU_REG_ADDR_W-1:0] rs_idx, rt_idx, dest_idx;
	opcode_t opcode_id_ex;
	alu_op_t alu_op;
	logic alu_src_imm, dren_id_ex, dwen_id_ex, reg_wen_id_ex;

	// EX/MEM and MEM/WB
	opcode_t opcode_ex_mem;
	logic zero_ex_mem, dren_ex_mem, dwen_ex_mem, reg_wen_ex_mem, wb_en;
	logic [`CPU_DATA_W-1:0] result_ex_mem, store_ex_mem, pc4_ex_mem, wb_data;
	logic [`CPU_REG_ADDR_W-1:0] dest_ex_mem, wb_reg;

	// fetch requests stop once the core halts
	assign imem_ren = ~halt;

	fetch_stage u_fetch (
		.restore_pc (pc4_ex_mem),
		.*
	);

	decode_stage u_decode (.*);

	execute_stage u_execute (.*);

	memory_stage u_memory (.*);

	hazard_unit u_hazard (
		.opcode_if_id (instr_if_id[31:26]),
		.funct_if_id  (instr_if_id[5:0]),
		.rs_if_id     (instr_if_id[25:21]),
		.rt_if_id     (instr_if_id[20:16]),
		.rt_id_ex     (rt_idx),
		.*
	);

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
// hazard unit
// global stall on memory wait and halt, branch mispredict
// recovery, load-use stall and next-pc source selection
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module hazard_unit (
	input  wire [5:0]                    opcode_if_id,
	input  wire [5:0]                    funct_if_id,
	input  wire [`CPU_REG_ADDR_W-1:0]    rs_if_id,
	input  wire [`CPU_REG_ADDR_W-1:0]    rt_if_id,
	input  wire [`CPU_REG_ADDR_W-1:0]    rt_id_ex,
	input  wire                          dren_id_ex,
	input  wire cpu_types_pkg::opcode_t  opcode_ex_mem,
	input  wire                          zero_ex_mem,
	input  wire                          dmem_ren,
	input  wire                          dmem_wen,
	input  wire                          dhit,
	input  wire                          ihit,
	input  wire                          halt,
	output logic                         enable_pc,
	output cpu_types_pkg::pc_sel_t       pc_sel,
	output logic                         enable_if_id,
	output logic                         enable_id_ex,
	output logic                         enable_ex_mem,
	output logic                         enable_mem_wb,
	output logic                         flush_if_id,
	output logic                         flush_id_ex,
	output logic                         flush_ex_mem,
	output logic                         flush_mem_wb
);
	import cpu_types_pkg::*;

	logic move, control_haz, load_haz;
	logic is_branch, is_jump, is_jr;

	// a pending data access needs dhit, otherwise wait for ihit
	// dhit never comes with ihit, so that advance has no fetched word
	assign move = ~halt & ((dmem_ren | dmem_wen) ? dhit : ihit);

	// predicted taken, so wrong when the compare says fall through
	assign control_haz = ((opcode_ex_mem == BEQ) & ~zero_ex_mem)
		| ((opcode_ex_mem == BNE) & zero_ex_mem);

	// load in ID/EX feeding the word in IF/ID
	assign load_haz = dren_id_ex & ((rt_id_ex == rs_if_id) | (rt_id_ex == rt_if_id));

	assign is_branch = (opcode_if_id == BEQ) | (opcode_if_id == BNE);
	assign is_jump   = (opcode_if_id == J) | (opcode_if_id == JAL);
	assign is_jr     = (opcode_if_id == RTYPE) & (funct_if_id == JR);

	always_comb begin
		pc_sel        = sel_next_instr;
		enable_if_id  = move;
		enable_id_ex  = move;
		enable_ex_mem = move;
		enable_mem_wb = move;
		// no fetched word, keep the pc and push a bubble into IF/ID
		enable_pc     = move & ihit;
		flush_if_id   = move & ~ihit;
		flush_id_ex   = 1'b0;
		flush_ex_mem  = 1'b0;
		flush_mem_wb  = 1'b0;

		if (move) begin
			if (control_haz) begin
				// squash the three wrong-path slots
				pc_sel       = sel_restore_pc;
				enable_pc    = 1'b1;
				flush_if_id  = 1'b1;
				flush_id_ex  = 1'b1;
				flush_ex_mem = 1'b1;
			end else if (load_haz) begin
				// hold pc and IF/ID, bubble into ID/EX
				enable_pc    = 1'b0;
				enable_if_id = 1'b0;
				flush_if_id  = 1'b0;
				flush_id_ex  = 1'b1;
			end else if (is_branch) begin
				pc_sel      = sel_br_addr;
				enable_pc   = 1'b1;
				flush_if_id = 1'b1;
			end else if (is_jump) begin
				pc_sel      = sel_jmp_addr;
				enable_pc   = 1'b1;
				flush_if_id = 1'b1;
			end else if (is_jr) begin
				pc_sel      = sel_jr_addr;
				enable_pc   = 1'b1;
				flush_if_id = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/memory_stage.sv ====
// memory stage
// data memory strobes, writeback select
// and the MEM/WB pipeline register with the halt bit
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module memory_stage (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          enable_mem_wb,
	input  wire                          flush_mem_wb,
	input  wire cpu_types_pkg::opcode_t  opcode_ex_mem,
	input  wire [`CPU_DATA_W-1:0]        result_ex_mem,
	input  wire [`CPU_DATA_W-1:0]        store_ex_mem,
	input  wire [`CPU_REG_ADDR_W-1:0]    dest_ex_mem,
	input  wire                          dren_ex_mem,
	input  wire                          dwen_ex_mem,
	input  wire                          reg_wen_ex_mem,
	input  wire [`CPU_DATA_W-1:0]        dmem_load,
	output logic [`CPU_DATA_W-1:0]       dmem_addr,
	output logic                         dmem_ren,
	output logic                         dmem_wen,
	output logic [`CPU_DATA_W-1:0]       dmem_store,
	output logic                         wb_en,
	output logic [`CPU_REG_ADDR_W-1:0]   wb_reg,
	output logic [`CPU_DATA_W-1:0]       wb_data,
	output logic                         halt
);
	import cpu_types_pkg::*;

	assign dmem_addr  = result_ex_mem;
	assign dmem_store = store_ex_mem;
	// anything behind a retired HALT never reaches memory
	assign dmem_ren = dren_ex_mem & ~halt;
	assign dmem_wen = dwen_ex_mem & ~halt;

	always_ff @(posedge clk) begin
		if (rst || flush_mem_wb) begin
			wb_en  <= 1'b0;
			wb_reg <= '0;
			halt   <= 1'b0;
		end else if (enable_mem_wb) begin
			wb_en  <= reg_wen_ex_mem;
			wb_reg <= dest_ex_mem;
			halt   <= (opcode_ex_mem == HALT);
		end
	end

	// load data is valid in the dhit cycle, which is when this enables
	always_ff @(posedge clk) begin
		if (enable_mem_wb)
			wb_data <= dren_ex_mem ? dmem_load : result_ex_mem;
	end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
// execute stage
// operand forwarding from EX/MEM and MEM/WB, the ALU,
// branch zero flag and the EX/MEM pipeline register
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module execute_stage (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          enable_ex_mem,
	input  wire                          flush_ex_mem,
	input  wire [`CPU_DATA_W-1:0]        rs_val,
	input  wire [`CPU_DATA_W-1:0]        rt_val,
	input  wire [`CPU_DATA_W-1:0]        imm,
	input  wire [`CPU_REG_ADDR_W-1:0]    rs_idx,
	input  wire [`CPU_REG_ADDR_W-1:0]    rt_idx,
	input  wire [`CPU_REG_ADDR_W-1:0]    dest_idx,
	input  wire cpu_types_pkg::opcode_t  opcode_id_ex,
	input  wire cpu_types_pkg::alu_op_t  alu_op,
	input  wire                          alu_src_imm,
	input  wire                          dren_id_ex,
	input  wire                          dwen_id_ex,
	input  wire                          reg_wen_id_ex,
	input  wire [`CPU_DATA_W-1:0]        pc4_id_ex,
	input  wire                          wb_en,
	input  wire [`CPU_REG_ADDR_W-1:0]    wb_reg,
	input  wire [`CPU_DATA_W-1:0]        wb_data,
	output cpu_types_pkg::opcode_t       opcode_ex_mem,
	output logic                         zero_ex_mem,
	output logic [`CPU_DATA_W-1:0]       result_ex_mem,
	output logic [`CPU_DATA_W-1:0]       store_ex_mem,
	output logic [`CPU_REG_ADDR_W-1:0]   dest_ex_mem,
	output logic                         dren_ex_mem,
	output logic                         dwen_ex_mem,
	output logic                         reg_wen_ex_mem,
	output logic [`CPU_DATA_W-1:0]       pc4_ex_mem
);
	import cpu_types_pkg::*;

	logic mem_fwd_rs, mem_fwd_rt, wb_fwd_rs, wb_fwd_rt, zero;
	logic [`CPU_DATA_W-1:0] op_a, fwd_rt, op_b, diff, alu_res, ex_result;

	// EX/MEM wins as the younger result
	// a load in EX/MEM has only its address, the load-use stall covers it
	assign mem_fwd_rs = reg_wen_ex_mem & ~dren_ex_mem & (dest_ex_mem == rs_idx)
		& (rs_idx != '0);
	assign mem_fwd_rt = reg_wen_ex_mem & ~dren_ex_mem & (dest_ex_mem == rt_idx)
		& (rt_idx != '0);
	assign wb_fwd_rs = wb_en & (wb_reg == rs_idx) & (rs_idx != '0);
	assign wb_fwd_rt = wb_en & (wb_reg == rt_idx) & (rt_idx != '0);

	assign op_a   = mem_fwd_rs ? result_ex_mem : wb_fwd_rs ? wb_data : rs_val;
	assign fwd_rt = mem_fwd_rt ? result_ex_mem : wb_fwd_rt ? wb_data : rt_val;
	assign op_b   = alu_src_imm ? imm : fwd_rt;

	// branch compare on the two register operands
	assign diff = op_a - fwd_rt;
	assign zero = (diff == '0);

	always_comb begin
		case (alu_op)
			ALU_SUB: alu_res = op_a - op_b;
			ALU_AND: alu_res = op_a & op_b;
			ALU_OR:  alu_res = op_a | op_b;
			ALU_SLT: alu_res = {{(`CPU_DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default: alu_res = op_a + op_b;
		endcase
	end

	// JAL writes its return address
	assign ex_result = (opcode_id_ex == JAL) ? pc4_id_ex : alu_res;

	always_ff @(posedge clk) begin
		if (rst || flush_ex_mem) begin
			opcode_ex_mem  <= RTYPE;
			zero_ex_mem    <= 1'b0;
			dest_ex_mem    <= '0;
			dren_ex_mem    <= 1'b0;
			dwen_ex_mem    <= 1'b0;
			reg_wen_ex_mem <= 1'b0;
		end else if (enable_ex_mem) begin
			opcode_ex_mem  <= opcode_id_ex;
			zero_ex_mem    <= zero;
			dest_ex_mem    <= dest_idx;
			dren_ex_mem    <= dren_id_ex;
			dwen_ex_mem    <= dwen_id_ex;
			reg_wen_ex_mem <= reg_wen_id_ex;
		end
	end

	// result, store data and fall-through pc
	always_ff @(posedge clk) begin
		if (enable_ex_mem) begin
			result_ex_mem <= ex_result;
			store_ex_mem  <= fwd_rt;
			pc4_ex_mem    <= pc4_id_ex;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// decode stage
// register file with write-first read, control decode
// and the ID/EX pipeline register
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module decode_stage (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          enable_id_ex,
	input  wire                          flush_id_ex,
	input  wire [`CPU_DATA_W-1:0]        instr_if_id,
	input  wire [`CPU_DATA_W-1:0]        pc4_if_id,
	input  wire                          wb_en,
	input  wire [`CPU_REG_ADDR_W-1:0]    wb_reg,
	input  wire [`CPU_DATA_W-1:0]        wb_data,
	output logic [`CPU_DATA_W-1:0]       jr_addr,
	output logic [`CPU_DATA_W-1:0]       rs_val,
	output logic [`CPU_DATA_W-1:0]       rt_val,
	output logic [`CPU_DATA_W-1:0]       imm,
	output logic [`CPU_REG_ADDR_W-1:0]   rs_idx,
	output logic [`CPU_REG_ADDR_W-1:0]   rt_idx,
	output logic [`CPU_REG_ADDR_W-1:0]   dest_idx,
	output cpu_types_pkg::opcode_t       opcode_id_ex,
	output cpu_types_pkg::alu_op_t       alu_op,
	output logic                         alu_src_imm,
	output logic                         dren_id_ex,
	output logic                         dwen_id_ex,
	output logic                         reg_wen_id_ex,
	output logic [`CPU_DATA_W-1:0]       pc4_id_ex
);
	import cpu_types_pkg::*;

	localparam int NUM_REGS = 1 << `CPU_REG_ADDR_W;

	logic [`CPU_DATA_W-1:0] regs [NUM_REGS];
	logic [`CPU_REG_ADDR_W-1:0] rs, rt, rd, dec_dest;
	logic [`CPU_DATA_W-1:0] rs_rd, rt_rd, dec_imm;
	opcode_t op;
	funct_t fn;
	alu_op_t dec_alu;
	logic dec_src_imm, dec_ren, dec_wen, dec_reg_wen;

	assign op  = opcode_t'(instr_if_id[31:26]);
	assign fn  = funct_t'(instr_if_id[5:0]);
	assign rs  = instr_if_id[25:21];
	assign rt  = instr_if_id[20:16];
	assign rd  = instr_if_id[15:11];
	assign dec_imm = {{(`CPU_DATA_W-16){instr_if_id[15]}}, instr_if_id[15:0]};

	// writeback lands at the same edge, so bypass it here
	always_comb begin
		rs_rd = regs[rs];
		rt_rd = regs[rt];
		if (wb_en && wb_reg == rs)
			rs_rd = wb_data;
		if (wb_en && wb_reg == rt)
			rt_rd = wb_data;
		// r0 is hardwired
		if (rs == '0)
			rs_rd = '0;
		if (rt == '0)
			rt_rd = '0;
	end

	// JR target straight from the file read
	assign jr_addr = rs_rd;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_reg != '0) begin
			regs[wb_reg] <= wb_data;
		end
	end

	always_comb begin
		dec_alu     = ALU_ADD;
		dec_src_imm = 1'b0;
		dec_ren     = 1'b0;
		dec_wen     = 1'b0;
		dec_reg_wen = 1'b0;
		dec_dest    = rd;
		case (op)
			RTYPE: begin
				dec_reg_wen = 1'b1;
				case (fn)
					ADDU:    dec_alu = ALU_ADD;
					SUBU:    dec_alu = ALU_SUB;
					AND:     dec_alu = ALU_AND;
					OR:      dec_alu = ALU_OR;
					SLT:     dec_alu = ALU_SLT;
					// JR and unknown functions write nothing
					default: dec_reg_wen = 1'b0;
				endcase
			end
			ADDIU: begin
				dec_src_imm = 1'b1;
				dec_reg_wen = 1'b1;
				dec_dest    = rt;
			end
			LW: begin
				dec_src_imm = 1'b1;
				dec_ren     = 1'b1;
				dec_reg_wen = 1'b1;
				dec_dest    = rt;
			end
			SW: begin
				dec_src_imm = 1'b1;
				dec_wen     = 1'b1;
			end
			BEQ, BNE: dec_alu = ALU_SUB;
			// link register is r31
			JAL: begin
				dec_reg_wen = 1'b1;
				dec_dest    = '1;
			end
			default: ;
		endcase
	end

	// ID/EX controls, a flush leaves a bubble
	always_ff @(posedge clk) begin
		if (rst || flush_id_ex) begin
			opcode_id_ex  <= RTYPE;
			alu_op        <= ALU_ADD;
			alu_src_imm   <= 1'b0;
			dren_id_ex    <= 1'b0;
			dwen_id_ex    <= 1'b0;
			reg_wen_id_ex <= 1'b0;
			rs_idx        <= '0;
			rt_idx        <= '0;
			dest_idx      <= '0;
		end else if (enable_id_ex) begin
			opcode_id_ex  <= op;
			alu_op        <= dec_alu;
			alu_src_imm   <= dec_src_imm;
			dren_id_ex    <= dec_ren;
			dwen_id_ex    <= dec_wen;
			reg_wen_id_ex <= dec_reg_wen;
			rs_idx        <= rs;
			rt_idx        <= rt;
			dest_idx      <= dec_dest;
		end
	end

	// operand payload
	always_ff @(posedge clk) begin
		if (enable_id_ex) begin
			rs_val    <= rs_rd;
			rt_val    <= rt_rd;
			imm       <= dec_imm;
			pc4_id_ex <= pc4_if_id;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
// fetch stage
// pc register, next-pc mux, branch and jump target adders
// and the IF/ID pipeline register
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module fetch_stage (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          enable_pc,
	input  wire cpu_types_pkg::pc_sel_t  pc_sel,
	input  wire                          enable_if_id,
	input  wire                          flush_if_id,
	input  wire [`CPU_DATA_W-1:0]        instr,
	input  wire [`CPU_DATA_W-1:0]        jr_addr,
	input  wire [`CPU_DATA_W-1:0]        restore_pc,
	output logic [`CPU_DATA_W-1:0]       imem_addr,
	output logic [`CPU_DATA_W-1:0]       instr_if_id,
	output logic [`CPU_DATA_W-1:0]       pc4_if_id
);
	import cpu_types_pkg::*;

	logic [`CPU_DATA_W-1:0] pc, pc4, next_pc, br_addr, jmp_addr;

	assign pc4 = pc + 4;
	assign imem_addr = pc;

	// targets come from the word already sitting in IF/ID
	// branch offset is sign extended and word scaled
	assign br_addr = pc4_if_id
		+ {{(`CPU_DATA_W-18){instr_if_id[15]}}, instr_if_id[15:0], 2'b00};
	// jump keeps the upper nibble of pc+4
	assign jmp_addr = {pc4_if_id[`CPU_DATA_W-1:28], instr_if_id[25:0], 2'b00};

	always_comb begin
		case (pc_sel)
			sel_br_addr:    next_pc = br_addr;
			sel_jmp_addr:   next_pc = jmp_addr;
			sel_jr_addr:    next_pc = jr_addr;
			// mispredicted branch falls through to its own pc+4
			sel_restore_pc: next_pc = restore_pc;
			default:        next_pc = pc4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= `CPU_RESET_PC;
		else if (enable_pc)
			pc <= next_pc;
	end

	// flush loads an all-zero word, decoded as a nop
	always_ff @(posedge clk) begin
		if (rst || flush_if_id) begin
			instr_if_id <= '0;
			pc4_if_id   <= '0;
		end else if (enable_if_id) begin
			instr_if_id <= instr;
			pc4_if_id   <= pc4;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cpu_types_pkg.sv ====
// shared core types
// major opcodes, r-type function codes,
// alu operations and next-pc sources
`default_nettype none

package cpu_types_pkg;

	// major opcode field, instr[31:26]
	typedef enum logic [5:0] {
		RTYPE = 6'h00,
		J     = 6'h02,
		JAL   = 6'h03,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDIU = 6'h09,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} opcode_t;

	// r-type function field, instr[5:0]
	typedef enum logic [5:0] {
		JR   = 6'h08,
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		SLT  = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_t;

	// five sources, so three bits
	typedef enum logic [2:0] {
		sel_next_instr,
		sel_br_addr,
		sel_jmp_addr,
		sel_jr_addr,
		sel_restore_pc
	} pc_sel_t;

endpackage

`default_nettype wire

// ==== include/cpu_config.svh ====
// core configuration macros
// data and address width, register index width
// and the pc value loaded at reset
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and address width
`define CPU_DATA_W 32

// register index width, 32 registers
`define CPU_REG_ADDR_W 5

// first fetch address
`define CPU_RESET_PC 32'h0000_0000

`endif
